/* flist.f */
+incdir+.
ob_pkg.sv
ob_locate.sv
ob_cancel.sv
ob_ctrl.sv
ob_store.sv
ob_outputs.sv
ob_table.sv
tb_ob_table.sv

/* ob_cancel.sv */
/*
  Cancel lookup by order id. Ids must be unique across the table and reject slot
  hit_entry is all zeros when nothing matches
*/

`timescale 1ns/1ps

module ob_cancel import ob_pkg::*; #(
  parameter int depth  = 8,
  parameter bit is_ask = 1'b1
) (
  input  entry_t [depth:0] slots,
  input  logic [depth:0]   slot_vld,
  input  uid_t             uid,
  output logic             match_any,
  output entry_t           hit_entry,
  output logic [depth:0]   shift_head
);

  // One-hot at most
  logic [depth:0] hit;

  always_comb begin
    for (int i = 0; i <= depth; i++) begin
      // Empty slots keep stale ids, so validity gates the compare
      hit[i] = slot_vld[i] && (slots[i].uid == uid);
    end
  end

  assign match_any = |hit;

  // OR mux of the matching slot
  always_comb begin
    hit_entry = '0;
    for (int i = 0; i <= depth; i++) begin
      if (hit[i]) begin
        hit_entry = entry_t'(hit_entry | slots[i]);
      end
    end
  end

  // Match and every slot below it pull from the tail neighbor
  // Closes the gap left by the removed entry
  always_comb begin
    logic seen;
    seen       = 1'b0;
    shift_head = '0;
    for (int i = depth; i >= 0; i--) begin
      seen          = seen | hit[i];
      shift_head[i] = seen;
    end
  end

endmodule

/* ob_ctrl.sv */
/*
  One table operation per cycle. Priority is head update, insert, cancel, pop
  Reject pop is dropped whenever another operation already moves the reject slot
*/

`timescale 1ns/1ps

module ob_ctrl import ob_pkg::*; #(
  parameter int depth  = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic                insert,
  input  logic                cancel,
  input  logic                head_pop,
  input  logic                head_upt,
  input  logic                reject_pop,
  input  logic [depth:0]      install,
  input  logic [depth:0]      shift_tail,
  input  logic [depth:0]      shift_head,
  input  logic                match_any,
  output move_e [depth:0]     move,
  output logic [depth:0]      slot_en,
  output logic                cancel_hit
);

  op_e op;

  // Fixed priority decode of the strobes
  always_comb begin
    if (head_upt) begin
      op = op_head_update;
    end else if (insert) begin
      op = op_insert;
    end else if (cancel) begin
      op = op_cancel;
    end else if (head_pop) begin
      op = op_pop;
    end else begin
      op = op_idle;
    end
  end

  // Per-slot move code
  always_comb begin
    for (int i = 0; i <= depth; i++) begin
      move[i] = mv_hold;
    end

    case (op)
      op_head_update: begin
        // Controller rewrites the head after a partial fill or similar
        move[depth] = mv_head_write;
      end

      op_insert: begin
        for (int i = 0; i <= depth; i++) begin
          if (install[i]) begin
            move[i] = mv_install;
          end else if (shift_tail[i]) begin
            move[i] = mv_from_head;
          end
        end
      end

      op_cancel: begin
        // shift_head is empty on a miss, so nothing moves
        for (int i = 1; i <= depth; i++) begin
          if (shift_head[i]) begin
            move[i] = mv_from_tail;
          end
        end
        if (shift_head[0]) begin
          move[0] = mv_clear;
        end
      end

      op_pop: begin
        // Whole table moves one toward the head
        // An unpopped reject re-enters at the tail slot
        for (int i = 1; i <= depth; i++) begin
          move[i] = mv_from_tail;
        end
        move[0] = mv_clear;
      end

      default: begin
      end
    endcase

    // Reject pop only when the reject slot is otherwise untouched
    if (reject_pop && (move[0] == mv_hold)) begin
      move[0] = mv_clear;
    end
  end

  always_comb begin
    for (int i = 0; i <= depth; i++) begin
      slot_en[i] = move[i] != mv_hold;
    end
  end

  // Same-cycle hit report only when the cancel wins arbitration
  assign cancel_hit = (op == op_cancel) && match_any;

endmodule

/* ob_locate.sv */
/*
  Finds where an incoming price lands. Equal prices go behind existing entries
  The reject slot always qualifies, so exactly one install bit is set
*/

`timescale 1ns/1ps

module ob_locate import ob_pkg::*; #(
  parameter int depth  = 8,
  parameter bit is_ask = 1'b1
) (
  input  entry_t [depth:0] slots,
  input  price_t           price,
  output logic [depth:0]   install,
  output logic [depth:0]   shift_tail
);

  // Slots whose entry the incoming price beats
  logic [depth:0] better;

  always_comb begin
    better = '0;
    for (int i = 1; i <= depth; i++) begin
      // Strict compare keeps time priority among equal prices
      if (is_ask) begin
        better[i] = price < slots[i].price;
      end else begin
        better[i] = price > slots[i].price;
      end
    end
    // Reject slot catches anything that finds no place in the table
    better[0] = 1'b1;
  end

  // Walk from the head down
  // First beaten slot takes the insert, everything below moves one toward the tail
  always_comb begin
    logic found;
    install    = '0;
    shift_tail = '0;
    found      = 1'b0;
    for (int i = depth; i >= 0; i--) begin
      if (found) begin
        shift_tail[i] = 1'b1;
      end else if (better[i]) begin
        install[i] = 1'b1;
        found      = 1'b1;
      end
    end
  end

endmodule

/* ob_outputs.sv */
/*
  Registered head and reject views one cycle behind the table operation
  Entries read as the empty entry right after reset
*/

`timescale 1ns/1ps

module ob_outputs import ob_pkg::*; #(
  parameter int depth  = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic   clk,
  input  logic   rst,
  input  entry_t head_next,
  input  logic   head_en,
  input  entry_t reject_next,
  input  logic   reject_en,
  output entry_t head,
  output logic   head_vld,
  output logic   head_did_update,
  output entry_t reject,
  output logic   reject_vld
);

  localparam price_t empty_p = empty_price(is_ask);
  localparam entry_t empty_e = empty_entry(is_ask);

  // Update flag pulses for one cycle per head write
  always_ff @(posedge clk) begin
    if (rst) begin
      head            <= empty_e;
      head_vld        <= 1'b0;
      head_did_update <= 1'b0;
    end else begin
      head_did_update <= head_en;
      if (head_en) begin
        head     <= head_next;
        head_vld <= head_next.price != empty_p;
      end
    end
  end

  // Reject valid holds until the slot is cleared or overwritten
  always_ff @(posedge clk) begin
    if (rst) begin
      reject     <= empty_e;
      reject_vld <= 1'b0;
    end else if (reject_en) begin
      reject     <= reject_next;
      reject_vld <= reject_next.price != empty_p;
    end
  end

endmodule

/* ob_pkg.sv */
/*
  Shared types for one side of the order book. Prices are plain unsigned binary
  An all-ones price on the ask side and a zero price on the bid side mark an empty slot
*/

package ob_pkg;

  // Field widths of a table entry
  localparam int uid_w   = 8;
  localparam int price_w = 16;
  localparam int qty_w   = 16;

  typedef logic [uid_w-1:0]   uid_t;
  typedef logic [price_w-1:0] price_t;
  typedef logic [qty_w-1:0]   qty_t;

  // One order, 40 bits, uid in the top byte
  typedef struct packed {
    uid_t   uid;
    price_t price;
    qty_t   qty;
  } entry_t;

  // Price limits
  localparam price_t price_max = '1;
  localparam price_t price_min = '0;

  // Table operation chosen for the cycle
  typedef enum logic [2:0] {
    op_idle,
    op_head_update,
    op_insert,
    op_cancel,
    op_pop
  } op_e;

  // What a slot loads on its enable
  typedef enum logic [2:0] {
    mv_hold,
    mv_install,
    mv_from_tail,
    mv_from_head,
    mv_head_write,
    mv_clear
  } move_e;

  // Empty-slot marker for the given side
  function automatic price_t empty_price(bit is_ask);
    return is_ask ? price_max : price_min;
  endfunction

  // Slot contents after reset
  function automatic entry_t empty_entry(bit is_ask);
    entry_t e;
    e       = '0;
    e.price = empty_price(is_ask);
    return e;
  endfunction

endpackage

/* ob_store.sv */
/*
  Table registers, slot depth is the head and slot 0 the reject slot
  A slot is valid exactly when its price differs from the side's empty price
*/

`timescale 1ns/1ps

module ob_store import ob_pkg::*; #(
  parameter int depth  = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic             clk,
  input  logic             rst,
  input  move_e [depth:0]  move,
  input  logic [depth:0]   slot_en,
  input  entry_t           insert_entry,
  input  entry_t           head_upt_entry,
  output entry_t [depth:0] slots,
  output logic [depth:0]   slot_vld,
  output entry_t           head_next,
  output logic             head_en,
  output entry_t           reject_next,
  output logic             reject_en
);

  localparam price_t empty_p = empty_price(is_ask);
  localparam entry_t empty_e = empty_entry(is_ask);

  // Neighbor views, end slots see themselves
  entry_t [depth:0] tail_nb;
  entry_t [depth:0] head_nb;
  entry_t [depth:0] slots_next;

  assign tail_nb = {slots[depth-1:0], slots[0]};
  assign head_nb = {slots[depth], slots[depth:1]};

  // Next value per slot from its move code
  always_comb begin
    for (int i = 0; i <= depth; i++) begin
      case (move[i])
        mv_install:    slots_next[i] = insert_entry;
        mv_from_tail:  slots_next[i] = tail_nb[i];
        mv_from_head:  slots_next[i] = head_nb[i];
        mv_head_write: slots_next[i] = head_upt_entry;
        mv_clear: begin
          // Id and quantity stay, only the price marks it empty
          slots_next[i]       = slots[i];
          slots_next[i].price = empty_p;
        end
        default:       slots_next[i] = slots[i];
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i <= depth; i++) begin
        slots[i] <= empty_e;
      end
    end else begin
      for (int i = 0; i <= depth; i++) begin
        if (slot_en[i]) begin
          slots[i] <= slots_next[i];
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i <= depth; i++) begin
      slot_vld[i] = slots[i].price != empty_p;
    end
  end

  // Next state of the two observable slots
  assign head_next   = slots_next[depth];
  assign head_en     = slot_en[depth];
  assign reject_next = slots_next[0];
  assign reject_en   = slot_en[0];

endmodule

/* ob_table.sv */
/*
  One side of a limit order book, depth live slots plus one reject slot
  One operation per cycle. An unpopped reject is overwritten by the next one
*/

`timescale 1ns/1ps

module ob_table import ob_pkg::*; #(
  parameter int depth  = 8,
  parameter bit is_ask = 1'b1
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   insert,
  input  entry_t insert_entry,
  input  logic   cancel,
  input  uid_t   cancel_uid,
  input  logic   head_pop,
  input  logic   head_upt,
  input  entry_t head_upt_entry,
  input  logic   reject_pop,
  output logic   cancel_hit,
  output entry_t cancel_hit_entry,
  output logic   head_vld,
  output logic   head_did_update,
  output entry_t head,
  output logic   reject_vld,
  output entry_t reject
);

  entry_t [depth:0] slots;
  logic [depth:0]   slot_vld;
  logic [depth:0]   install;
  logic [depth:0]   shift_tail;
  logic [depth:0]   shift_head;
  logic             match_any;
  move_e [depth:0]  move;
  logic [depth:0]   slot_en;
  entry_t           head_next;
  entry_t           reject_next;
  logic             head_en;
  logic             reject_en;

  ob_store #(.depth(depth), .is_ask(is_ask)) u_store (
    .clk            (clk),
    .rst            (rst),
    .move           (move),
    .slot_en        (slot_en),
    .insert_entry   (insert_entry),
    .head_upt_entry (head_upt_entry),
    .slots          (slots),
    .slot_vld       (slot_vld),
    .head_next      (head_next),
    .head_en        (head_en),
    .reject_next    (reject_next),
    .reject_en      (reject_en)
  );

  // Insert position, computed every cycle
  ob_locate #(.depth(depth), .is_ask(is_ask)) u_locate (
    .slots      (slots),
    .price      (insert_entry.price),
    .install    (install),
    .shift_tail (shift_tail)
  );

  // Hit entry goes straight out, qualified by cancel_hit
  ob_cancel #(.depth(depth), .is_ask(is_ask)) u_cancel (
    .slots      (slots),
    .slot_vld   (slot_vld),
    .uid        (cancel_uid),
    .match_any  (match_any),
    .hit_entry  (cancel_hit_entry),
    .shift_head (shift_head)
  );

  ob_ctrl #(.depth(depth), .is_ask(is_ask)) u_ctrl (
    .insert     (insert),
    .cancel     (cancel),
    .head_pop   (head_pop),
    .head_upt   (head_upt),
    .reject_pop (reject_pop),
    .install    (install),
    .shift_tail (shift_tail),
    .shift_head (shift_head),
    .match_any  (match_any),
    .move       (move),
    .slot_en    (slot_en),
    .cancel_hit (cancel_hit)
  );

  ob_outputs #(.depth(depth), .is_ask(is_ask)) u_outputs (
    .clk             (clk),
    .rst             (rst),
    .head_next       (head_next),
    .head_en         (head_en),
    .reject_next     (reject_next),
    .reject_en       (reject_en),
    .head            (head),
    .head_vld        (head_vld),
    .head_did_update (head_did_update),
    .reject          (reject),
    .reject_vld      (reject_vld)
  );

endmodule

/* tb_ob_vectors.svh */
/*
  Vector table for the 4-deep ask table. Entries are written as uid_price_qty in hex
  Head and reject entries are only compared while their valid flag is expected high
*/

`ifndef tb_ob_vectors_svh
`define tb_ob_vectors_svh

// stim_row takes operation, entry as uid_price_qty and reject pop
// expect_row takes cancel_hit, hit entry, head_vld, head, head_did_update, reject_vld, reject
task automatic load_steps();
  // 50 then 30 takes the head and 40 lands behind it
  stim_row(op_insert, 40'h01_0032_000a, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h01_0032_000a, 1'b1, 1'b0, 40'h0);
  stim_row(op_insert, 40'h02_001e_0014, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h02_001e_0014, 1'b1, 1'b0, 40'h0);
  stim_row(op_insert, 40'h03_0028_001e, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h02_001e_0014, 1'b0, 1'b0, 40'h0);
  // Second order at 30 queues behind the first
  stim_row(op_insert, 40'h04_001e_0028, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h02_001e_0014, 1'b0, 1'b0, 40'h0);
  stim_row(op_pop, 40'h0, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b1, 1'b0, 40'h0);
  // 35 fills the table between 30 and 40
  stim_row(op_insert, 40'h07_0023_0046, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b0, 40'h0);
  // Worse than a full table goes straight to reject
  stim_row(op_insert, 40'h05_003c_0032, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b1, 40'h05_003c_0032);
  stim_row(op_idle, 40'h0, 1'b1);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b0, 40'h0);
  // 45 displaces the tail at 50
  stim_row(op_insert, 40'h06_002d_003c, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b1, 40'h01_0032_000a);
  // New reject overwrites and the reject pop loses to it
  stim_row(op_insert, 40'h08_0046_0050, 1'b1);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b1, 40'h08_0046_0050);
  stim_row(op_idle, 40'h0, 1'b1);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b0, 40'h0);
  // Cancel the order at 40, then id 08 which only lingers in empty slots
  stim_row(op_cancel, 40'h03_0000_0000, 1'b0);
  expect_row(1'b1, 40'h03_0028_001e, 1'b1, 40'h04_001e_0028, 1'b0, 1'b0, 40'h0);
  stim_row(op_cancel, 40'h08_0000_0000, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h04_001e_0028, 1'b0, 1'b0, 40'h0);
  // Pops walk the closed-up table
  stim_row(op_pop, 40'h0, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h07_0023_0046, 1'b1, 1'b0, 40'h0);
  stim_row(op_pop, 40'h0, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h06_002d_003c, 1'b1, 1'b0, 40'h0);
  // Partial fill leaves quantity 20 at the head
  stim_row(op_head_update, 40'h06_002d_0014, 1'b0);
  expect_row(1'b0, 40'h0, 1'b1, 40'h06_002d_0014, 1'b1, 1'b0, 40'h0);
  // Last pop empties the table
  stim_row(op_pop, 40'h0, 1'b0);
  expect_row(1'b0, 40'h0, 1'b0, 40'h0, 1'b1, 1'b0, 40'h0);
endtask

`endif

/* tb_ob_table.sv */
/*
  Testbench for a 4-deep ask table, steps come from tb_ob_vectors.svh
  Each step takes two clocks, the strobe cycle and one idle cycle
*/

`timescale 1ns/1ps

module tb_ob_table import ob_pkg::*; ();

  localparam int tb_depth      = 4;
  localparam int clk_ns        = 100;
  localparam int reset_cycles  = 8;
  localparam int margin_cycles = 20;

  logic   clk;
  logic   rst;
  logic   insert;
  entry_t insert_entry;
  logic   cancel;
  uid_t   cancel_uid;
  logic   head_pop;
  logic   head_upt;
  entry_t head_upt_entry;
  logic   reject_pop;
  logic   cancel_hit;
  entry_t cancel_hit_entry;
  logic   head_vld;
  logic   head_did_update;
  entry_t head;
  logic   reject_vld;
  entry_t reject;

  // One row of the vector table, stimulus first
  typedef struct packed {
    op_e    op;
    entry_t e;
    logic   rpop;
    logic   exp_hit;
    entry_t exp_hit_e;
    logic   exp_hv;
    entry_t exp_head;
    logic   exp_hu;
    logic   exp_rv;
    entry_t exp_reject;
  } step_t;

  step_t steps[$];
  step_t pending;
  int    cur_step;

  ob_table #(.depth(tb_depth), .is_ask(1'b1)) dut (
    .clk              (clk),
    .rst              (rst),
    .insert           (insert),
    .insert_entry     (insert_entry),
    .cancel           (cancel),
    .cancel_uid       (cancel_uid),
    .head_pop         (head_pop),
    .head_upt         (head_upt),
    .head_upt_entry   (head_upt_entry),
    .reject_pop       (reject_pop),
    .cancel_hit       (cancel_hit),
    .cancel_hit_entry (cancel_hit_entry),
    .head_vld         (head_vld),
    .head_did_update  (head_did_update),
    .head             (head),
    .reject_vld       (reject_vld),
    .reject           (reject)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_ns / 2) clk = ~clk;
  end

  // Start a row with its stimulus
  task automatic stim_row(op_e op, entry_t e, logic rpop);
    pending      = '0;
    pending.op   = op;
    pending.e    = e;
    pending.rpop = rpop;
  endtask

  // Close the row with its expected results and queue it
  task automatic expect_row(logic hit, entry_t hit_e, logic hv, entry_t h, logic hu,
                            logic rv, entry_t r);
    pending.exp_hit    = hit;
    pending.exp_hit_e  = hit_e;
    pending.exp_hv     = hv;
    pending.exp_head   = h;
    pending.exp_hu     = hu;
    pending.exp_rv     = rv;
    pending.exp_reject = r;
    steps.push_back(pending);
  endtask

  `include "tb_ob_vectors.svh"

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error %s at step %0d: got %h expected %h", name, cur_step, got, exp);
      $display("Testbench failed");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_entry(string name, entry_t got, entry_t exp);
    if (got !== exp) begin
      $display("error %s at step %0d: got %h expected %h", name, cur_step, got, exp);
      $display("Testbench failed");
      $fatal(1, "entry mismatch");
    end
  endtask

  // One strobe per op, the entry doubles as insert, update and cancel id
  task automatic drive_step(step_t s);
    insert         <= (s.op == op_insert);
    insert_entry   <= s.e;
    cancel         <= (s.op == op_cancel);
    cancel_uid     <= s.e.uid;
    head_pop       <= (s.op == op_pop);
    head_upt       <= (s.op == op_head_update);
    head_upt_entry <= s.e;
    reject_pop     <= s.rpop;
  endtask

  task automatic drive_idle();
    insert     <= 1'b0;
    cancel     <= 1'b0;
    head_pop   <= 1'b0;
    head_upt   <= 1'b0;
    reject_pop <= 1'b0;
  endtask

  initial begin
    load_steps();
    cur_step       = 0;
    rst            <= 1'b1;
    insert         <= 1'b0;
    insert_entry   <= '0;
    cancel         <= 1'b0;
    cancel_uid     <= '0;
    head_pop       <= 1'b0;
    head_upt       <= 1'b0;
    head_upt_entry <= '0;
    reject_pop     <= 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    // Flags low straight out of reset
    @(negedge clk);
    check_bit("head_vld", head_vld, 1'b0);
    check_bit("reject_vld", reject_vld, 1'b0);
    check_bit("head_did_update", head_did_update, 1'b0);
    foreach (steps[i]) begin
      cur_step = i + 1;
      @(posedge clk);
      drive_step(steps[i]);
      // Cancel result is combinational in the strobe cycle
      @(negedge clk);
      check_bit("cancel_hit", cancel_hit, steps[i].exp_hit);
      if (steps[i].exp_hit) begin
        check_entry("cancel_hit_entry", cancel_hit_entry, steps[i].exp_hit_e);
      end
      // Previous cycle was idle, so no update pulse may linger
      check_bit("head_did_update", head_did_update, 1'b0);
      @(posedge clk);
      drive_idle();
      // Registered view one clock after the strobe
      @(negedge clk);
      check_bit("head_vld", head_vld, steps[i].exp_hv);
      check_bit("head_did_update", head_did_update, steps[i].exp_hu);
      check_bit("reject_vld", reject_vld, steps[i].exp_rv);
      if (steps[i].exp_hv) begin
        check_entry("head", head, steps[i].exp_head);
      end
      if (steps[i].exp_rv) begin
        check_entry("reject", reject, steps[i].exp_reject);
      end
    end
    $display("Testbench passed");
    $finish;
  end

  // Limit follows the table length, read once the rows are loaded
  initial begin
    int limit_cycles;
    #1;
    limit_cycles = reset_cycles + 2 * steps.size() + margin_cycles;
    #(limit_cycles * clk_ns);
    $display("watchdog: run did not finish within %0d clock cycles", limit_cycles);
    $display("Testbench failed");
    $fatal(1, "timeout");
  end

endmodule
